// ==== tb.f ====
design/id_pkg.sv
design/id_ctrl.sv
design/id_decoder.sv
design/id_regfile.sv
design/id_bypass.sv
design/id_branch.sv
design/id_stage.sv
tests/id_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -f tb.f --top-module id_stage_tb -o id_stage_sim
./obj_dir/id_stage_sim > sim.log 2>&1
cat sim.log
if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== tests/id_stage_tb.sv ====
// needs --assert; stimulus changes on the rising edge and every check samples on the falling edge
module id_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_STEPS = 100;  // issues plus writebacks, sizes the watchdog

  logic i_clk, i_rst, i_fs_valid, i_es_allowin, i_ws_rf_wen, i_es_load_sel;
  logic [id_pkg::INST_W-1:0] i_fs_inst;
  logic [id_pkg::XLEN-1:0] i_fs_pc, i_ws_rf_wdata, i_es_result, i_ms_result, i_ws_result;
  logic [id_pkg::REG_AW-1:0] i_ws_rf_waddr, i_es_rd, i_ms_rd, i_ws_rd;
  logic o_ds_allowin, o_ds_to_es_valid, o_br_taken, o_br_stall, o_alu_src1_pc, o_alu_src2_imm;
  logic o_gpr_wen, o_mem_ren, o_mem_wen, o_load_sel, o_invalid;
  logic [id_pkg::XLEN-1:0] o_br_target, o_rs1_data, o_rs2_data, o_imm, o_pc;
  logic [id_pkg::REG_AW-1:0] o_rd;
  logic [2:0] o_mem_size;
  id_pkg::alu_op_e o_alu_op;

  logic [id_pkg::XLEN-1:0] exp_rs1, exp_rs2, exp_imm, exp_pc, exp_target;
  logic [12:0] exp_ctrl, ctrl_mask, ctrl_vec;
  logic [5:0] exp_side, side_vec;
  logic [3:0] exp_hs, hs_vec;
  logic exp_taken, chk_ops, chk_imm, chk_ctrl, chk_side, chk_hs, chk_br, chk_hold;
  logic [id_pkg::XLEN-1:0] shadow [id_pkg::NUM_REGS];  // expected register contents
  logic [31:0] lfsr;
  int errors = 0;
  int checks;
  string test_name;

  id_stage i_id_stage (.*);

  assign ctrl_vec = {o_rd, o_alu_op, o_gpr_wen, o_mem_ren, o_mem_wen, o_invalid};
  assign side_vec = {o_alu_src1_pc, o_alu_src2_imm, o_mem_size, o_load_sel};
  assign hs_vec   = {o_ds_to_es_valid, o_ds_allowin, o_br_taken, o_br_stall};

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    repeat (NUM_STEPS * 20 + 200) @(posedge i_clk);
    $display("watchdog expired, the tests did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic report_mismatch(input string what, input logic [127:0] exp, act);
    $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    errors++;
  endtask

  a_ops: assert property (@(negedge i_clk) chk_ops |->
    (o_rs1_data == exp_rs1 && o_rs2_data == exp_rs2))
    else report_mismatch("operands", {exp_rs1, exp_rs2}, {o_rs1_data, o_rs2_data});
  a_pc: assert property (@(negedge i_clk) chk_ops |-> (o_pc == exp_pc))
    else report_mismatch("pc", 128'(exp_pc), 128'(o_pc));
  a_imm: assert property (@(negedge i_clk) chk_imm |-> (o_imm == exp_imm))
    else report_mismatch("imm", 128'(exp_imm), 128'(o_imm));
  a_ctrl: assert property (@(negedge i_clk) chk_ctrl |-> (((ctrl_vec ^ exp_ctrl) & ctrl_mask) == '0))
    else report_mismatch("ctrl", 128'(exp_ctrl & ctrl_mask), 128'(ctrl_vec & ctrl_mask));
  a_side: assert property (@(negedge i_clk) chk_side |-> (side_vec == exp_side))
    else report_mismatch("operand select", 128'(exp_side), 128'(side_vec));
  a_hs: assert property (@(negedge i_clk) chk_hs |-> (hs_vec == exp_hs))
    else report_mismatch("handshake", 128'(exp_hs), 128'(hs_vec));
  a_branch: assert property (@(negedge i_clk) chk_br |->
    (o_br_taken == exp_taken && (!exp_taken || o_br_target == exp_target)))
    else report_mismatch("branch", 128'({exp_taken, exp_target}), 128'({o_br_taken, o_br_target}));
  a_hold: assert property (@(negedge i_clk) chk_hold |->
    (!o_ds_allowin && $stable(o_pc) && $stable(o_imm)))
    else begin
      $display("FAIL %s: latched instruction moved while execute was blocked", test_name);
      errors++;
    end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic [63:0] sext(input logic [63:0] v, input int w);
    return $signed(v << (64 - w)) >>> (64 - w);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input id_pkg::opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, id_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], id_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                       input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OP_BRANCH};
  endfunction

  function automatic logic [12:0] pack_ctrl(input logic [4:0] rd, input id_pkg::alu_op_e alu,
                                            input logic gw, mr, mw, inv);
    return {rd, alu, gw, mr, mw, inv};
  endfunction

  // pc as first operand, imm as second, access size and load flag
  function automatic logic [5:0] side_bits(input logic [31:0] inst);
    logic [6:0] op;
    logic src1_pc;
    logic src2_imm;
    op = inst[6:0];
    src1_pc = (op == id_pkg::OP_AUIPC) || (op == id_pkg::OP_JAL) || (op == id_pkg::OP_JALR);
    src2_imm = (op == id_pkg::OP_IMM) || (op == id_pkg::OP_LOAD) || (op == id_pkg::OP_STORE) ||
               (op == id_pkg::OP_LUI) || (op == id_pkg::OP_AUIPC);
    return {src1_pc, src2_imm, inst[14:12], op == id_pkg::OP_LOAD};
  endfunction

  // conditions as the ISA defines them
  function automatic logic branch_holds(input logic [2:0] f3, input logic [63:0] a, b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic wb_write(input logic [4:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_ws_rf_wen   <= 1'b1;
    i_ws_rf_waddr <= addr;
    i_ws_rf_wdata <= data;
    shadow[addr] = (addr == 5'd0) ? '0 : data;
    @(posedge i_clk);
    i_ws_rf_wen <= 1'b0;
  endtask

  // returns at the accepting edge
  task automatic issue(input logic [31:0] inst, input logic [63:0] pc);
    @(posedge i_clk);
    i_fs_valid <= 1'b1;
    i_fs_inst  <= inst;
    i_fs_pc    <= pc;
    @(negedge i_clk);
    while (!o_ds_allowin) @(negedge i_clk);
    @(posedge i_clk);
    i_fs_valid <= 1'b0;
  endtask

  task automatic end_check();
    @(posedge i_clk);
    chk_ops  <= 1'b0;
    chk_imm  <= 1'b0;
    chk_ctrl <= 1'b0;
    chk_side <= 1'b0;
    chk_hs   <= 1'b0;
    chk_br   <= 1'b0;
    checks++;
  endtask

  task automatic check_decode(input string name, input logic [31:0] inst,
                              input logic [63:0] e_rs1, e_rs2, e_imm, input logic imm_on,
                              input logic [12:0] e_ctrl, mask);
    logic [63:0] pc;
    pc = rand_bits(62) << 2;
    issue(inst, pc);
    test_name = name;
    exp_rs1   <= e_rs1;
    exp_rs2   <= e_rs2;
    exp_imm   <= e_imm;
    exp_pc    <= pc;
    exp_ctrl  <= e_ctrl;
    ctrl_mask <= mask;
    exp_side  <= side_bits(inst);
    chk_ops   <= 1'b1;
    chk_imm   <= imm_on;
    chk_ctrl  <= 1'b1;
    chk_side  <= !e_ctrl[0];
    end_check();
  endtask

  task automatic fwd_case(input string name, input logic [4:0] es, ms, ws, rs1,
                          input logic [63:0] exp);
    @(posedge i_clk);
    i_es_rd <= es;
    i_ms_rd <= ms;
    i_ws_rd <= ws;
    check_decode(name, enc_r(7'h00, 5'd9, rs1, 3'b000, 5'd1), exp, shadow[9], '0, 1'b0,
                 pack_ctrl(5'd1, id_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0), '1);
  endtask

  // load in execute writing es_rd, add x1 = rs1 + x9 in decode
  task automatic hs_case(input string name, input logic [4:0] es_rd, rs1, input logic [3:0] hs);
    @(posedge i_clk);
    i_es_load_sel <= 1'b1;
    i_es_rd       <= es_rd;
    issue(enc_r(7'h00, 5'd9, rs1, 3'b000, 5'd1), rand_bits(62) << 2);
    test_name = name;
    exp_hs <= hs;
    chk_hs <= 1'b1;
    end_check();
    i_es_load_sel <= 1'b0;
    i_es_rd       <= '0;
  endtask

  task automatic branch_case(input string name, input logic [31:0] inst, input logic [63:0] pc,
                             input logic taken, input logic [63:0] target);
    issue(inst, pc);
    test_name  = name;
    exp_taken  <= taken;
    exp_target <= target;
    chk_br     <= 1'b1;
    end_check();
  endtask

  initial begin
    logic [63:0] v, w, a, b, pc, pc_b, r_es, r_ms, r_ws;
    lfsr = 32'h226d;
    checks = 0;
    test_name = "reset";
    {chk_ops, chk_imm, chk_ctrl, chk_side, chk_hs, chk_br, chk_hold} <= '0;
    {exp_rs1, exp_rs2, exp_imm, exp_pc, exp_target} <= '0;
    {exp_ctrl, ctrl_mask, exp_side, exp_hs, exp_taken} <= '0;
    i_rst <= 1'b1;
    {i_fs_valid, i_ws_rf_wen, i_es_load_sel} <= '0;
    i_es_allowin <= 1'b1;
    {i_fs_inst, i_fs_pc, i_ws_rf_wdata} <= '0;
    {i_es_result, i_ms_result, i_ws_result} <= '0;
    {i_ws_rf_waddr, i_es_rd, i_ms_rd, i_ws_rd} <= '0;
    repeat (10) @(posedge i_clk);
    i_rst  <= 1'b0;
    exp_hs <= 4'b0100;
    chk_hs <= 1'b1;
    end_check();

    for (int r = 1; r < 32; r++) wb_write(5'(r), rand_bits(64));
    wb_write(5'd0, rand_bits(64));  // must not stick
    v = rand_bits(12);
    check_decode("addi", enc_i(v[11:0], 5'd3, 3'b000, 5'd7, id_pkg::OP_IMM), shadow[3], '0,
                 sext(v, 12), 1'b1, pack_ctrl(5'd7, id_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0), '1);
    check_decode("add", enc_r(7'h00, 5'd9, 5'd3, 3'b000, 5'd8), shadow[3], shadow[9], '0, 1'b0,
                 pack_ctrl(5'd8, id_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0), '1);
    check_decode("sub", enc_r(7'h20, 5'd13, 5'd12, 3'b000, 5'd2), shadow[12], shadow[13], '0,
                 1'b0, pack_ctrl(5'd2, id_pkg::ALU_SUB, 1'b1, 1'b0, 1'b0, 1'b0), '1);
    v = rand_bits(12);
    check_decode("lw", enc_i(v[11:0], 5'd14, 3'b010, 5'd15, id_pkg::OP_LOAD), shadow[14], '0,
                 sext(v, 12), 1'b1, pack_ctrl(5'd15, id_pkg::ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0), '1);
    v = rand_bits(12);
    check_decode("sd", enc_s(v[11:0], 5'd16, 5'd17, 3'b011), shadow[17], shadow[16], sext(v, 12),
                 1'b1, pack_ctrl(5'd0, id_pkg::ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0), '1);
    v = rand_bits(20);
    check_decode("lui", {v[19:0], 5'd18, id_pkg::OP_LUI}, '0, '0, sext(v << 12, 32), 1'b1,
                 pack_ctrl(5'd18, id_pkg::ALU_LUI, 1'b1, 1'b0, 1'b0, 1'b0), '1);
    check_decode("x0 read", enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd19), '0, '0, '0, 1'b0,
                 pack_ctrl(5'd19, id_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0), '1);
    check_decode("undefined opcode", {v[6:0], 18'd0, 7'b1111111}, '0, '0, '0, 1'b0,
                 13'b0_0000_0000_0001, 13'h00f);
    check_decode("addw dropped", {25'd0, 7'b0111011}, '0, '0, '0, 1'b0,
                 13'b0_0000_0000_0001, 13'h00f);

    r_es = rand_bits(64);
    r_ms = rand_bits(64);
    r_ws = rand_bits(64);
    @(posedge i_clk);
    i_es_result <= r_es;
    i_ms_result <= r_ms;
    i_ws_result <= r_ws;
    fwd_case("fwd es", 5'd8, 5'd8, 5'd8, 5'd8, r_es);
    fwd_case("fwd ms", 5'd0, 5'd8, 5'd8, 5'd8, r_ms);
    fwd_case("fwd ws", 5'd0, 5'd0, 5'd8, 5'd8, r_ws);
    fwd_case("fwd none", 5'd0, 5'd0, 5'd0, 5'd8, shadow[8]);
    fwd_case("fwd rd0", 5'd0, 5'd0, 5'd0, 5'd0, '0);

    hs_case("no stall rd0", 5'd0, 5'd0, 4'b1100);
    hs_case("no stall mismatch", 5'd7, 5'd3, 4'b1100);
    hs_case("load-use rs2", 5'd9, 5'd3, 4'b0000);
    v = rand_bits(12);
    pc = rand_bits(62) << 2;
    @(posedge i_clk);
    i_es_load_sel <= 1'b1;
    i_es_rd       <= 5'd3;
    issue(enc_i(v[11:0], 5'd3, 3'b000, 5'd1, id_pkg::OP_JALR), pc);
    test_name  = "load-use jalr";
    exp_taken  <= 1'b1;
    exp_target <= (r_es + sext(v, 12)) & ~64'd1;
    chk_br     <= 1'b1;
    exp_hs     <= 4'b0011;
    chk_hs     <= 1'b1;
    end_check();
    i_es_load_sel <= 1'b0;
    i_es_rd       <= '0;
    test_name  = "load-use release";
    exp_hs     <= 4'b1110;
    chk_hs     <= 1'b1;
    exp_target <= (shadow[3] + sext(v, 12)) & ~64'd1;
    chk_br     <= 1'b1;
    end_check();

    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      for (int round = 0; round < 2; round++) begin
        a = rand_bits(64);
        b = (round == 1) ? a : rand_bits(64);
        wb_write(5'd10, a);
        wb_write(5'd11, b);
        v = rand_bits(11) << 2;
        pc = rand_bits(62) << 2;
        branch_case($sformatf("branch f3=%0d", f), enc_b(v[12:0], 5'd11, 5'd10, 3'(f)), pc,
                    branch_holds(3'(f), a, b), pc + sext(v, 13));
      end
    end
    v = rand_bits(19) << 2;
    pc = rand_bits(62) << 2;
    branch_case("jal", {v[20], v[10:1], v[11], v[19:12], 5'd1, id_pkg::OP_JAL}, pc, 1'b1,
                pc + sext(v, 21));
    v = rand_bits(12);
    branch_case("jalr", enc_i(v[11:0], 5'd10, 3'b000, 5'd1, id_pkg::OP_JALR), pc, 1'b1,
                (shadow[10] + sext(v, 12)) & ~64'd1);

    // execute blocked, fetch keeps offering the next instruction
    v = rand_bits(12);
    w = rand_bits(12);
    pc_b = rand_bits(62) << 2;
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    issue(enc_i(v[11:0], 5'd3, 3'b000, 5'd7, id_pkg::OP_IMM), rand_bits(62) << 2);
    i_fs_valid <= 1'b1;
    i_fs_inst  <= enc_i(w[11:0], 5'd4, 3'b000, 5'd8, id_pkg::OP_IMM);
    i_fs_pc    <= pc_b;
    test_name = "back-pressure";
    @(posedge i_clk);
    chk_hold <= 1'b1;
    exp_hs   <= 4'b1000;
    chk_hs   <= 1'b1;
    repeat (4) @(posedge i_clk);
    i_es_allowin <= 1'b1;
    chk_hold     <= 1'b0;
    chk_hs       <= 1'b0;
    @(posedge i_clk);  // offered instruction taken here
    i_fs_valid <= 1'b0;
    test_name = "back-pressure accept";
    exp_pc  <= pc_b;
    exp_imm <= sext(w, 12);
    exp_rs1 <= shadow[4];
    exp_rs2 <= '0;
    chk_ops <= 1'b1;
    chk_imm <= 1'b1;
    end_check();

    repeat (2) @(posedge i_clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== design/id_stage.sv ====
// rv64i decode stage top; one instruction in flight, outputs valid only with o_ds_to_es_valid
module id_stage (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_fs_valid,
  input  logic [id_pkg::INST_W-1:0] i_fs_inst,
  input  logic [id_pkg::XLEN-1:0]   i_fs_pc,
  output logic                      o_ds_allowin,
  input  logic                      i_es_allowin,
  output logic                      o_ds_to_es_valid,
  input  logic                      i_ws_rf_wen,
  input  logic [id_pkg::REG_AW-1:0] i_ws_rf_waddr,
  input  logic [id_pkg::XLEN-1:0]   i_ws_rf_wdata,
  input  logic                      i_es_load_sel,
  input  logic [id_pkg::REG_AW-1:0] i_es_rd,
  input  logic [id_pkg::XLEN-1:0]   i_es_result,
  input  logic [id_pkg::REG_AW-1:0] i_ms_rd,
  input  logic [id_pkg::XLEN-1:0]   i_ms_result,
  input  logic [id_pkg::REG_AW-1:0] i_ws_rd,
  input  logic [id_pkg::XLEN-1:0]   i_ws_result,
  output logic                      o_br_taken,
  output logic [id_pkg::XLEN-1:0]   o_br_target,
  output logic                      o_br_stall,
  output logic [id_pkg::XLEN-1:0]   o_rs1_data,
  output logic [id_pkg::XLEN-1:0]   o_rs2_data,
  output logic [id_pkg::XLEN-1:0]   o_imm,
  output logic [id_pkg::XLEN-1:0]   o_pc,
  output logic [id_pkg::REG_AW-1:0] o_rd,
  output id_pkg::alu_op_e           o_alu_op,
  output logic                      o_alu_src1_pc,
  output logic                      o_alu_src2_imm,
  output logic                      o_gpr_wen,
  output logic                      o_mem_ren,
  output logic                      o_mem_wen,
  output logic [2:0]                o_mem_size,
  output logic                      o_load_sel,
  output logic                      o_invalid
);

  logic                      ds_valid;
  logic                      load_stall;
  logic [id_pkg::INST_W-1:0] ds_inst;
  logic [id_pkg::REG_AW-1:0] rs1;
  logic [id_pkg::REG_AW-1:0] rs2;
  logic [id_pkg::XLEN-1:0]   rf_rdata1;
  logic [id_pkg::XLEN-1:0]   rf_rdata2;
  id_pkg::br_func_e          br_func;
  id_pkg::jump_e             jump;

  assign o_load_sel = o_mem_ren;  // execute flags loads back for the stall

  id_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_rd          (i_es_rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_valid       (ds_valid),
    .o_load_stall     (load_stall),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2_imm (o_alu_src2_imm),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_invalid      (o_invalid),
    .o_mem_size     (o_mem_size),
    .o_br_func      (br_func),
    .o_jump         (jump)
  );

  id_regfile u_regfile (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_rf_wen),
    .i_waddr  (i_ws_rf_waddr),
    .i_wdata  (i_ws_rf_wdata),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_bypass u_bypass (
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_rf_rdata1 (rf_rdata1),
    .i_rf_rdata2 (rf_rdata2),
    .i_es_rd     (i_es_rd),
    .i_es_result (i_es_result),
    .i_ms_rd     (i_ms_rd),
    .i_ms_result (i_ms_result),
    .i_ws_rd     (i_ws_rd),
    .i_ws_result (i_ws_result),
    .o_rs1_data  (o_rs1_data),
    .o_rs2_data  (o_rs2_data)
  );

  id_branch u_branch (
    .i_valid      (ds_valid),
    .i_jump       (jump),
    .i_br_func    (br_func),
    .i_rs1_data   (o_rs1_data),
    .i_rs2_data   (o_rs2_data),
    .i_pc         (o_pc),
    .i_imm        (o_imm),
    .i_load_stall (load_stall),
    .o_br_taken   (o_br_taken),
    .o_br_target  (o_br_target),
    .o_br_stall   (o_br_stall)
  );

endmodule

// ==== design/id_branch.sv ====
// branch unit; offsets are assumed word aligned, a misaligned target raises no exception
module id_branch (
  input  logic                    i_valid,
  input  id_pkg::jump_e           i_jump,
  input  id_pkg::br_func_e        i_br_func,
  input  logic [id_pkg::XLEN-1:0] i_rs1_data,
  input  logic [id_pkg::XLEN-1:0] i_rs2_data,
  input  logic [id_pkg::XLEN-1:0] i_pc,
  input  logic [id_pkg::XLEN-1:0] i_imm,
  input  logic                    i_load_stall,
  output logic                    o_br_taken,
  output logic [id_pkg::XLEN-1:0] o_br_target,
  output logic                    o_br_stall
);

  logic                    cond;
  logic                    is_jalr;
  logic [id_pkg::XLEN-1:0] sum;

  always_comb begin
    case (i_br_func)
      id_pkg::BR_EQ:  cond = (i_rs1_data == i_rs2_data);
      id_pkg::BR_NE:  cond = (i_rs1_data != i_rs2_data);
      id_pkg::BR_LT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      id_pkg::BR_GE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      id_pkg::BR_LTU: cond = (i_rs1_data < i_rs2_data);
      id_pkg::BR_GEU: cond = (i_rs1_data >= i_rs2_data);
      default:        cond = 1'b0;
    endcase
  end

  assign is_jalr    = (i_jump == id_pkg::JMP_JALR);
  assign o_br_taken = i_valid && (is_jalr || i_jump == id_pkg::JMP_JAL ||
                                  (i_jump == id_pkg::JMP_BRANCH && cond));
  assign sum        = (is_jalr ? i_rs1_data : i_pc) + i_imm;

  // jalr drops bit 0, otherwise fall through
  assign o_br_target = o_br_taken ? {sum[id_pkg::XLEN-1:1], sum[0] & ~is_jalr}
                                  : i_pc + id_pkg::PC_STEP;
  assign o_br_stall  = o_br_taken && i_load_stall;  // fetch must hold the redirect

  always_comb begin
    if (o_br_taken && !is_jalr && i_pc[1:0] == 2'b00) begin
      a_target_aligned: assert (o_br_target[1:0] == 2'b00)
        else $error("branch target %h not word aligned", o_br_target);
    end
  end

endmodule

// ==== design/id_bypass.sv ====
// operand forwarding; later stages must report rd 0 for bubbles and non-writing instructions
module id_bypass (
  input  logic [id_pkg::REG_AW-1:0] i_rs1,
  input  logic [id_pkg::REG_AW-1:0] i_rs2,
  input  logic [id_pkg::XLEN-1:0]   i_rf_rdata1,
  input  logic [id_pkg::XLEN-1:0]   i_rf_rdata2,
  input  logic [id_pkg::REG_AW-1:0] i_es_rd,
  input  logic [id_pkg::XLEN-1:0]   i_es_result,
  input  logic [id_pkg::REG_AW-1:0] i_ms_rd,
  input  logic [id_pkg::XLEN-1:0]   i_ms_result,
  input  logic [id_pkg::REG_AW-1:0] i_ws_rd,
  input  logic [id_pkg::XLEN-1:0]   i_ws_result,
  output logic [id_pkg::XLEN-1:0]   o_rs1_data,
  output logic [id_pkg::XLEN-1:0]   o_rs2_data
);

  // youngest producer wins
  function automatic logic [id_pkg::XLEN-1:0] pick(
    input logic [id_pkg::REG_AW-1:0] rs,
    input logic [id_pkg::XLEN-1:0]   rf_data
  );
    if (i_es_rd != '0 && i_es_rd == rs) begin
      return i_es_result;
    end else if (i_ms_rd != '0 && i_ms_rd == rs) begin
      return i_ms_result;
    end else if (i_ws_rd != '0 && i_ws_rd == rs) begin
      return i_ws_result;  // covers the rf write in flight
    end
    return rf_data;
  endfunction

  always_comb begin
    o_rs1_data = pick(i_rs1, i_rf_rdata1);
    o_rs2_data = pick(i_rs2, i_rf_rdata2);
  end

endmodule

// ==== design/id_regfile.sv ====
// 32 x 64 register file without reset; a write is not seen on the read ports until the next cycle
module id_regfile (
  input  logic                      i_clk,
  input  logic [id_pkg::REG_AW-1:0] i_raddr1,
  input  logic [id_pkg::REG_AW-1:0] i_raddr2,
  input  logic                      i_wen,
  input  logic [id_pkg::REG_AW-1:0] i_waddr,
  input  logic [id_pkg::XLEN-1:0]   i_wdata,
  output logic [id_pkg::XLEN-1:0]   o_rdata1,
  output logic [id_pkg::XLEN-1:0]   o_rdata2
);

  logic [id_pkg::XLEN-1:0] regs [id_pkg::NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 is hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // last cycle's write shows up on port 1
  a_write_visible: assert property (@(posedge i_clk)
    (i_raddr1 != '0 && $past(i_wen) && $past(i_waddr) == i_raddr1)
      |-> (o_rdata1 == $past(i_wdata)));

endmodule

// ==== design/id_decoder.sv ====
// rv64i subset decoder; W-suffix, fence and system encodings all report invalid
module id_decoder (
  input  logic [id_pkg::INST_W-1:0] i_inst,
  output logic [id_pkg::REG_AW-1:0] o_rs1,
  output logic [id_pkg::REG_AW-1:0] o_rs2,
  output logic [id_pkg::REG_AW-1:0] o_rd,
  output logic [id_pkg::XLEN-1:0]   o_imm,
  output id_pkg::alu_op_e           o_alu_op,
  output logic                      o_alu_src1_pc,
  output logic                      o_alu_src2_imm,
  output logic                      o_gpr_wen,
  output logic                      o_mem_ren,
  output logic                      o_mem_wen,
  output logic                      o_invalid,
  output logic [2:0]                o_mem_size,
  output id_pkg::br_func_e          o_br_func,
  output id_pkg::jump_e             o_jump
);

  id_pkg::opcode_e         opcode;
  id_pkg::alu_op_e         arith_op;
  logic                    arith_ok;
  logic                    mem_ok;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [id_pkg::XLEN-1:0] imm_i;
  logic [id_pkg::XLEN-1:0] imm_s;
  logic [id_pkg::XLEN-1:0] imm_b;
  logic [id_pkg::XLEN-1:0] imm_u;
  logic [id_pkg::XLEN-1:0] imm_j;

  assign opcode     = id_pkg::opcode_e'(i_inst[6:0]);
  assign funct3     = i_inst[14:12];
  assign funct7     = i_inst[31:25];
  assign o_mem_size = funct3;
  assign mem_ok     = (funct3 == 3'b010) || (funct3 == 3'b011);  // lw, ld

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shared by OP and OP-IMM
  always_comb begin
    arith_ok = 1'b1;
    case (funct3)
      3'b000:  arith_op = (opcode == id_pkg::OP_REG && funct7[5]) ? id_pkg::ALU_SUB
                                                                  : id_pkg::ALU_ADD;
      3'b001:  arith_op = id_pkg::ALU_SLL;
      3'b010:  arith_op = id_pkg::ALU_SLT;
      3'b011:  arith_op = id_pkg::ALU_SLTU;
      3'b100:  arith_op = id_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
      3'b110:  arith_op = id_pkg::ALU_OR;
      default: arith_op = id_pkg::ALU_AND;
    endcase
    if (opcode == id_pkg::OP_REG) begin
      arith_ok = (funct7 == 7'h00) ||
                 (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
    end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
      // 6-bit shamt, only srai sets bit 30
      arith_ok = (i_inst[31:26] == 6'b0) || (funct3 == 3'b101 && i_inst[31:26] == 6'b010000);
    end
  end

  always_comb begin
    o_rs1          = i_inst[19:15];
    o_rs2          = '0;
    o_rd           = i_inst[11:7];
    o_imm          = imm_i;
    o_alu_op       = id_pkg::ALU_ADD;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_imm = 1'b1;
    o_gpr_wen      = 1'b1;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_invalid      = 1'b0;
    o_br_func      = id_pkg::BR_EQ;
    o_jump         = id_pkg::JMP_NONE;
    case (opcode)
      id_pkg::OP_LUI: begin
        o_rs1    = '0;
        o_imm    = imm_u;
        o_alu_op = id_pkg::ALU_LUI;
      end
      id_pkg::OP_AUIPC: begin
        o_rs1         = '0;
        o_imm         = imm_u;
        o_alu_src1_pc = 1'b1;
      end
      id_pkg::OP_JAL, id_pkg::OP_JALR: begin
        o_alu_src1_pc  = 1'b1;
        o_alu_src2_imm = 1'b0;  // execute adds PC_STEP for the link
        if (opcode == id_pkg::OP_JAL) begin
          o_rs1  = '0;
          o_imm  = imm_j;
          o_jump = id_pkg::JMP_JAL;
        end else begin
          o_jump    = id_pkg::JMP_JALR;
          o_invalid = (funct3 != 3'b000);
        end
      end
      id_pkg::OP_BRANCH: begin
        o_rs2          = i_inst[24:20];
        o_rd           = '0;
        o_imm          = imm_b;
        o_alu_op       = id_pkg::ALU_SUB;
        o_alu_src2_imm = 1'b0;
        o_gpr_wen      = 1'b0;
        o_jump         = id_pkg::JMP_BRANCH;
        o_br_func      = id_pkg::br_func_e'(funct3);
        o_invalid      = (funct3[2:1] == 2'b01);  // 010 and 011 unused
      end
      id_pkg::OP_LOAD: begin
        o_mem_ren = 1'b1;
        o_invalid = !mem_ok;
      end
      id_pkg::OP_STORE: begin
        o_rs2     = i_inst[24:20];
        o_rd      = '0;
        o_imm     = imm_s;
        o_gpr_wen = 1'b0;
        o_mem_wen = 1'b1;
        o_invalid = !mem_ok;
      end
      id_pkg::OP_IMM: begin
        o_alu_op  = arith_op;
        o_invalid = !arith_ok;
      end
      id_pkg::OP_REG: begin
        o_rs2          = i_inst[24:20];
        o_alu_op       = arith_op;
        o_alu_src2_imm = 1'b0;
        o_invalid      = !arith_ok;
      end
      default: o_invalid = 1'b1;
    endcase
    // keep a bad encoding from writing, jumping or stalling on stray fields
    if (o_invalid) begin
      o_rs1     = '0;
      o_rs2     = '0;
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      o_jump    = id_pkg::JMP_NONE;
    end
  end

endmodule

// ==== design/id_ctrl.sv ====
// decode latch and handshake; payload is unreset, and execute must drive i_es_rd to 0 when empty
module id_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_fs_valid,
  input  logic [id_pkg::INST_W-1:0] i_fs_inst,
  input  logic [id_pkg::XLEN-1:0]   i_fs_pc,
  input  logic                      i_es_allowin,
  input  logic                      i_es_load_sel,
  input  logic [id_pkg::REG_AW-1:0] i_es_rd,
  input  logic [id_pkg::REG_AW-1:0] i_rs1,
  input  logic [id_pkg::REG_AW-1:0] i_rs2,
  output logic                      o_ds_allowin,
  output logic                      o_ds_to_es_valid,
  output logic                      o_ds_valid,
  output logic                      o_load_stall,
  output logic [id_pkg::INST_W-1:0] o_inst,
  output logic [id_pkg::XLEN-1:0]   o_pc
);

  logic                      ds_valid;
  logic                      rd_hit;
  logic [id_pkg::INST_W-1:0] inst_r;
  logic [id_pkg::XLEN-1:0]   pc_r;

  assign rd_hit = (i_es_rd != '0) && ((i_es_rd == i_rs1) || (i_es_rd == i_rs2));

  // load result only exists once it reaches mem
  assign o_load_stall     = ds_valid && i_es_load_sel && rd_hit;
  assign o_ds_allowin     = !ds_valid || (!o_load_stall && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && !o_load_stall;
  assign o_ds_valid       = ds_valid;
  assign o_inst           = inst_r;
  assign o_pc             = pc_r;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // empty again if fetch has nothing
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      inst_r <= i_fs_inst;
      pc_r   <= i_fs_pc;
    end
  end

  // an issued instruction with nothing behind it leaves the stage empty
  a_drain_empties: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_ds_to_es_valid && i_es_allowin && !i_fs_valid) |=> !ds_valid);

  // a blocked instruction stays put until execute takes it
  a_hold_blocked: assert property (@(posedge i_clk) disable iff (i_rst)
    (ds_valid && !o_ds_allowin) |=> (ds_valid && $stable(inst_r) && $stable(pc_r)));

endmodule

// ==== design/id_pkg.sv ====
// shared rv64i decode definitions; W-suffix ops, CSRs and system opcodes are not encoded here
package id_pkg;

  localparam int XLEN     = 64;  // data and pc width
  localparam int INST_W   = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  localparam logic [XLEN-1:0] PC_STEP = XLEN'(4);  // fall-through increment

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_LUI  = 4'd10   // passes imm through
  } alu_op_e;

  // same encoding as branch funct3
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_func_e;

  typedef enum logic [1:0] {
    JMP_NONE   = 2'd0,
    JMP_BRANCH = 2'd1,
    JMP_JAL    = 2'd2,
    JMP_JALR   = 2'd3
  } jump_e;

endpackage
